//--- sources.f
common/mipsPkg.sv
decode/controlDecoder.sv
decode/registerFile.sv
decode/decodeStage.sv
verilog/fetchStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/mipsCore.sv
testbench/mipsCore_asserts.sv
testbench/mipsCoreTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module mipsCoreTb -o mipsSim
./obj_dir/mipsSim | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

//--- testbench/mipsCoreTb.sv
`timescale 1ns/10ps

module mipsCoreTb import mipsPkg::*; ();

	localparam int NumTests = 5;
	localparam int MaxLen = 16;
	localparam int MaxExp = 12;
	localparam int ResetCycles = 16;
	localparam int TailCycles = 8;

	logic Clk;
	logic rstN;
	word_t pc;
	word_t instr;
	memWb_t wb;

	// Program and expected write reports, one row per test
	string testName [NumTests];
	word_t progTable [NumTests][MaxLen];
	int progLen [NumTests];
	regAddr_t expReg [NumTests][MaxExp];
	word_t expData [NumTests][MaxExp];
	int expCount [NumTests];
	int pcCheckCycle [NumTests];
	word_t pcCheckValue [NumTests];

	int seed;
	int curTest;
	int expIdx;
	int testErrors;
	int errors;
	int passCount;
	int failCount;
	int cycleCount;
	int cycleLimit;

	mipsCore #(.DataWords(64), .ResetPc(32'h0)) dut_i (
		.Clk(Clk),
		.rstN(rstN),
		.pc(pc),
		.instr(instr),
		.wb(wb)
	);

	always #50 Clk = ~Clk;

	// Program store answers pc in the same cycle
	always @(posedge Clk) begin
		#1;
		instr = fetchWord(pc);
	end

	always @(posedge Clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: run exceeded %0d cycles", cycleLimit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic word_t fetchWord(word_t addr);
		if ((addr >> 2) < word_t'(progLen[curTest]))
			return progTable[curTest][addr[5:2]];
		return '0; // Outside the program
	endfunction

	function automatic word_t rType(logic [5:0] fn, regAddr_t rd, regAddr_t rs, regAddr_t rt);
		return {OpSpecial, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t iType(logic [5:0] op, regAddr_t rs, regAddr_t rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t signExtend(logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic word_t zeroExtend(logic [15:0] v);
		return {16'h0, v};
	endfunction

	task automatic appendInstr(int t, word_t w);
		progTable[t][progLen[t]] = w;
		progLen[t]++;
	endtask

	task automatic appendNops(int t, int n);
		repeat (n) appendInstr(t, 32'h0); // Spacing for dependent instructions
	endtask

	task automatic expectWrite(int t, regAddr_t r, word_t d);
		expReg[t][expCount[t]] = r;
		expData[t][expCount[t]] = d;
		expCount[t]++;
	endtask

	task automatic buildTables();
		word_t a;
		word_t b;
		word_t rnd;
		logic [15:0] lo1;
		logic [15:0] lo2;
		for (int t = 0; t < NumTests; t++) begin
			progLen[t] = 0;
			expCount[t] = 0;
			pcCheckCycle[t] = 6;
			pcCheckValue[t] = 32'd24;
		end
		a = 32'd100;
		b = 32'd37;
		testName[0] = "R-type";
		appendInstr(0, iType(OpAddi, 5'd0, 5'd1, 16'd100));
		appendInstr(0, iType(OpAddi, 5'd0, 5'd2, 16'd37));
		appendNops(0, 2);
		appendInstr(0, rType(FnAdd, 5'd3, 5'd1, 5'd2));
		appendInstr(0, rType(FnSub, 5'd4, 5'd1, 5'd2));
		appendInstr(0, rType(FnAnd, 5'd5, 5'd1, 5'd2));
		appendInstr(0, rType(FnOr, 5'd6, 5'd1, 5'd2));
		appendInstr(0, rType(FnXor, 5'd7, 5'd1, 5'd2));
		appendInstr(0, rType(FnNor, 5'd8, 5'd1, 5'd2));
		appendInstr(0, rType(FnSlt, 5'd9, 5'd1, 5'd2));
		appendInstr(0, rType(FnSlt, 5'd10, 5'd2, 5'd1));
		appendInstr(0, rType(FnSub, 5'd11, 5'd2, 5'd1));
		appendNops(0, 2);
		appendInstr(0, rType(FnSlt, 5'd12, 5'd11, 5'd1)); // Negative operand
		expectWrite(0, 5'd1, a);
		expectWrite(0, 5'd2, b);
		expectWrite(0, 5'd3, a + b);
		expectWrite(0, 5'd4, a - b);
		expectWrite(0, 5'd5, a & b);
		expectWrite(0, 5'd6, a | b);
		expectWrite(0, 5'd7, a ^ b);
		expectWrite(0, 5'd8, ~(a | b));
		expectWrite(0, 5'd9, word_t'($signed(a) < $signed(b)));
		expectWrite(0, 5'd10, word_t'($signed(b) < $signed(a)));
		expectWrite(0, 5'd11, b - a);
		expectWrite(0, 5'd12, word_t'($signed(b - a) < $signed(a)));

		testName[1] = "immediates";
		appendInstr(1, iType(OpAddi, 5'd0, 5'd1, 16'hfff0));
		appendInstr(1, iType(OpOri, 5'd0, 5'd2, 16'h8001));
		appendNops(1, 2);
		appendInstr(1, iType(OpAndi, 5'd1, 5'd3, 16'hff0f));
		appendInstr(1, iType(OpOri, 5'd1, 5'd4, 16'h800f));
		appendInstr(1, iType(OpAddiu, 5'd2, 5'd5, 16'h8000));
		expectWrite(1, 5'd1, signExtend(16'hfff0));
		expectWrite(1, 5'd2, zeroExtend(16'h8001));
		expectWrite(1, 5'd3, signExtend(16'hfff0) & zeroExtend(16'hff0f));
		expectWrite(1, 5'd4, signExtend(16'hfff0) | zeroExtend(16'h800f));
		expectWrite(1, 5'd5, zeroExtend(16'h8001) + signExtend(16'h8000));

		// No LUI, so stored words are built from random 16-bit immediates
		rnd = $random(seed);
		lo1 = rnd[15:0];
		rnd = $random(seed);
		lo2 = rnd[15:0];
		testName[2] = "memory";
		appendInstr(2, iType(OpOri, 5'd0, 5'd1, lo1));
		appendInstr(2, iType(OpAddi, 5'd0, 5'd2, lo2));
		appendNops(2, 2);
		appendInstr(2, iType(OpSw, 5'd0, 5'd1, 16'd8));
		appendInstr(2, iType(OpSw, 5'd0, 5'd2, 16'd20));
		appendInstr(2, iType(OpLw, 5'd0, 5'd3, 16'd8));
		appendInstr(2, iType(OpLw, 5'd0, 5'd4, 16'd20));
		expectWrite(2, 5'd1, zeroExtend(lo1));
		expectWrite(2, 5'd2, signExtend(lo2));
		expectWrite(2, 5'd3, zeroExtend(lo1));
		expectWrite(2, 5'd4, signExtend(lo2));

		testName[3] = "branches";
		appendInstr(3, iType(OpAddi, 5'd0, 5'd1, 16'd5));
		appendInstr(3, iType(OpAddi, 5'd0, 5'd2, 16'd5));
		appendNops(3, 2);
		appendInstr(3, iType(OpBeq, 5'd1, 5'd2, 16'd3)); // Taken, lands on slot 8
		appendInstr(3, iType(OpAddi, 5'd0, 5'd3, 16'd1));
		appendInstr(3, iType(OpAddi, 5'd0, 5'd4, 16'd2));
		appendInstr(3, iType(OpAddi, 5'd0, 5'd5, 16'd3));
		appendInstr(3, iType(OpBne, 5'd1, 5'd2, 16'd5));
		appendInstr(3, iType(OpAddi, 5'd0, 5'd6, 16'd9));
		appendInstr(3, iType(OpAddi, 5'd0, 5'd7, 16'd11));
		expectWrite(3, 5'd1, 32'd5);
		expectWrite(3, 5'd2, 32'd5);
		expectWrite(3, 5'd6, 32'd9);
		expectWrite(3, 5'd7, 32'd11);
		pcCheckCycle[3] = 4 + 3;
		pcCheckValue[3] = 32'd20 + (signExtend(16'd3) << 2);

		testName[4] = "register zero";
		appendInstr(4, iType(OpAddi, 5'd0, 5'd0, 16'd55));
		appendInstr(4, iType(OpAddi, 5'd0, 5'd1, 16'd42));
		appendNops(4, 2);
		appendInstr(4, rType(FnAdd, 5'd2, 5'd1, 5'd0));
		appendInstr(4, rType(FnAdd, 5'd3, 5'd0, 5'd1));
		appendInstr(4, rType(FnAdd, 5'd0, 5'd1, 5'd1));
		appendNops(4, 2);
		appendInstr(4, rType(FnAdd, 5'd4, 5'd0, 5'd1));
		expectWrite(4, 5'd1, 32'd42);
		expectWrite(4, 5'd2, 32'd42);
		expectWrite(4, 5'd3, 32'd42);
		expectWrite(4, 5'd4, 32'd42);

		cycleLimit = 50;
		for (int t = 0; t < NumTests; t++)
			cycleLimit += progLen[t] + TailCycles + ResetCycles + 2;
	endtask

	task automatic checkCycle(int t, int k);
		word_t expPc;
		if (k <= pcCheckCycle[t]) begin
			expPc = (k == pcCheckCycle[t]) ? pcCheckValue[t] : word_t'(4 * k);
			assert (pc == expPc) else begin
				$display("Fail test %0d cycle %0d pc: got %h expected %h", t, k, pc, expPc);
				testErrors++;
			end
		end
		if (wb.valid) begin
			if (expIdx >= expCount[t]) begin
				$display("Test %0d cycle %0d: unexpected write report to register %0d",
					t, k, wb.dest);
				testErrors++;
			end else begin
				assert (wb.dest == expReg[t][expIdx]) else begin
					$display("Fail test %0d wb.dest: got %h expected %h",
						t, wb.dest, expReg[t][expIdx]);
					testErrors++;
				end
				assert (wb.data == expData[t][expIdx]) else begin
					$display("Fail test %0d wb.data: got %h expected %h",
						t, wb.data, expData[t][expIdx]);
					testErrors++;
				end
				expIdx++;
			end
		end
	endtask

	task automatic runTest(int t);
		curTest = t;
		expIdx = 0;
		testErrors = 0;
		@(posedge Clk);
		#1 rstN = 1'b0;
		repeat (ResetCycles) begin
			@(negedge Clk);
			assert (pc == 32'h0) else begin
				$display("Fail test %0d pc in reset: got %h expected %h", t, pc, 32'h0);
				testErrors++;
			end
			assert (!wb.valid) else begin
				$display("Fail test %0d wb.valid in reset: got %h expected %h", t, wb.valid, 1'b0);
				testErrors++;
			end
		end
		@(posedge Clk);
		#1 rstN = 1'b1;
		for (int k = 0; k < progLen[t] + TailCycles; k++) begin
			@(negedge Clk);
			checkCycle(t, k);
		end
		if (expIdx < expCount[t]) begin
			$display("Test %0d: only %0d of %0d write reports arrived", t, expIdx, expCount[t]);
			testErrors++;
		end
		if (testErrors == 0) begin
			$display("Test %0d %s: passed", t, testName[t]);
			passCount++;
		end else begin
			$display("Test %0d %s: failed with %0d errors", t, testName[t], testErrors);
			failCount++;
		end
		errors += testErrors;
	endtask

	initial begin
		Clk = 1'b0;
		rstN = 1'b0;
		instr = '0;
		seed = 32'h8c8e_2bef;
		cycleCount = 0;
		errors = 0;
		passCount = 0;
		failCount = 0;
		curTest = 0;
		buildTables();
		for (int t = 0; t < NumTests; t++)
			runTest(t);
		$display("Tests %0d, passed %0d, failed %0d, errors %0d",
			NumTests, passCount, failCount, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- testbench/mipsCore_asserts.sv
`timescale 1ns/10ps

module mipsCoreAsserts import mipsPkg::*; (
	input logic Clk,
	input logic rstN,
	input word_t pc,
	input memWb_t wb
);

	noZeroReport: assert property (@(posedge Clk) disable iff (!rstN) wb.valid |-> wb.dest != '0)
		else $error("write report for register 0");

	pcAligned: assert property (@(posedge Clk) pc[1:0] == 2'b00)
		else $error("pc not word aligned");

	// Observation port stays quiet while held in reset
	quietInReset: assert property (@(posedge Clk) !rstN |-> !wb.valid)
		else $error("wb.valid high during reset");

endmodule

bind mipsCore mipsCoreAsserts asserts_i (.Clk(Clk), .rstN(rstN), .pc(pc), .wb(wb));

//--- verilog/mipsCore.sv
`timescale 1ns/10ps

module mipsCore import mipsPkg::*; #(
	parameter int DataWords = 64,
	parameter word_t ResetPc = '0
) (
	input logic Clk,
	input logic rstN,
	output word_t pc,
	input word_t instr,
	output memWb_t wb
);

	word_t ifInstr;
	word_t ifPcPlus4;
	logic branchTaken;
	word_t branchTarget;
	idEx_t idEx;
	exMem_t exMem;

	fetchStage #(.ResetPc(ResetPc)) fetch_i (
		.Clk(Clk),
		.rstN(rstN),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.instr(instr),
		.pc(pc),
		.ifInstr(ifInstr),
		.ifPcPlus4(ifPcPlus4)
	);

	// Taken branch doubles as the flush
	decodeStage decode_i (
		.Clk(Clk),
		.rstN(rstN),
		.ifInstr(ifInstr),
		.ifPcPlus4(ifPcPlus4),
		.flush(branchTaken),
		.memWb(wb),
		.idEx(idEx)
	);

	executeStage execute_i (
		.Clk(Clk),
		.rstN(rstN),
		.idEx(idEx),
		.exMem(exMem),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget)
	);

	memoryStage #(.DataWords(DataWords)) memory_i (
		.Clk(Clk),
		.rstN(rstN),
		.exMem(exMem),
		.memWb(wb)
	);

endmodule

//--- verilog/memoryStage.sv
`timescale 1ns/10ps

module memoryStage import mipsPkg::*; #(
	parameter int DataWords = 64
) (
	input logic Clk,
	input logic rstN,
	input exMem_t exMem,
	output memWb_t memWb
);

	localparam int AddrBits = $clog2(DataWords);

	word_t dataMem [DataWords];
	logic [AddrBits-1:0] wordIdx;
	word_t loadData;
	word_t wbData;

	// Byte offset dropped, upper bits wrap
	assign wordIdx = exMem.aluResult[AddrBits+1:2];

	always_ff @(posedge Clk) begin
		if (exMem.valid && exMem.memWrite)
			dataMem[wordIdx] <= exMem.storeData;
	end

	assign loadData = dataMem[wordIdx];
	assign wbData = exMem.memRead ? loadData : exMem.aluResult;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			memWb.valid <= 1'b0;
		end else begin
			memWb.valid <= exMem.valid & exMem.regWrite;
			memWb.dest <= exMem.dest;
			memWb.data <= wbData;
		end
	end

endmodule

//--- verilog/executeStage.sv
`timescale 1ns/10ps

module executeStage import mipsPkg::*; (
	input logic Clk,
	input logic rstN,
	input idEx_t idEx,
	output exMem_t exMem,
	output logic branchTaken,
	output word_t branchTarget
);

	word_t aluB;
	word_t aluResult;
	logic zero;

	assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : idEx.rtData;

	always_comb begin
		case (idEx.ctrl.aluOp)
			AluAnd: aluResult = idEx.rsData & aluB;
			AluOr: aluResult = idEx.rsData | aluB;
			AluAdd: aluResult = idEx.rsData + aluB;
			AluSub: aluResult = idEx.rsData - aluB;
			AluSlt: aluResult = {31'b0, $signed(idEx.rsData) < $signed(aluB)};
			AluXor: aluResult = idEx.rsData ^ aluB;
			AluNor: aluResult = ~(idEx.rsData | aluB);
			default: aluResult = '0;
		endcase
	end

	assign zero = (aluResult == '0);

	// Resolved here, younger two slots get flushed
	assign branchTaken = idEx.valid
		& ((idEx.ctrl.branchEq & zero) | (idEx.ctrl.branchNe & ~zero));
	assign branchTarget = idEx.pcPlus4 + {idEx.imm[29:0], 2'b00};

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			exMem.valid <= 1'b0;
			exMem.regWrite <= 1'b0;
			exMem.memRead <= 1'b0;
			exMem.memWrite <= 1'b0;
		end else begin
			exMem.valid <= idEx.valid;
			exMem.regWrite <= idEx.ctrl.regWrite;
			exMem.memRead <= idEx.ctrl.memRead;
			exMem.memWrite <= idEx.ctrl.memWrite;
			exMem.aluResult <= aluResult;
			exMem.storeData <= idEx.rtData; // SW data is rt
			exMem.dest <= idEx.dest;
		end
	end

endmodule

//--- verilog/fetchStage.sv
`timescale 1ns/10ps

module fetchStage import mipsPkg::*; #(
	parameter word_t ResetPc = '0
) (
	input logic Clk,
	input logic rstN,
	input logic branchTaken,
	input word_t branchTarget,
	input word_t instr,
	output word_t pc,
	output word_t ifInstr,
	output word_t ifPcPlus4
);

	typedef struct packed {
		word_t instr;
		word_t pcPlus4;
	} ifId_t;

	ifId_t ifId;
	word_t pcPlus4;

	assign pcPlus4 = pc + 32'd4;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN)
			pc <= ResetPc;
		else
			pc <= branchTaken ? branchTarget : pcPlus4;
	end

	// Zero word is a bubble downstream
	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			ifId.instr <= '0;
		end else begin
			ifId.instr <= branchTaken ? '0 : instr;
			ifId.pcPlus4 <= pcPlus4;
		end
	end

	assign ifInstr = ifId.instr;
	assign ifPcPlus4 = ifId.pcPlus4;

endmodule

//--- decode/decodeStage.sv
`timescale 1ns/10ps

module decodeStage import mipsPkg::*; (
	input logic Clk,
	input logic rstN,
	input word_t ifInstr,
	input word_t ifPcPlus4,
	input logic flush,
	input memWb_t memWb,
	output idEx_t idEx
);

	ctrl_t decCtrl;
	logic decValid;
	word_t rsData;
	word_t rtData;
	word_t immExt;
	regAddr_t dest;

	controlDecoder decoder_i (
		.instr(ifInstr),
		.ctrl(decCtrl),
		.valid(decValid)
	);

	registerFile regFile_i (
		.Clk(Clk),
		.rstN(rstN),
		.rsAddr(ifInstr[25:21]),
		.rtAddr(ifInstr[20:16]),
		.wr(memWb),
		.rsData(rsData),
		.rtData(rtData)
	);

	assign dest = (ifInstr[31:26] == OpSpecial) ? ifInstr[15:11] : ifInstr[20:16]; // rd or rt
	assign immExt = decCtrl.zeroExtend ? {16'b0, ifInstr[15:0]}
		: {{16{ifInstr[15]}}, ifInstr[15:0]};

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			idEx.valid <= 1'b0;
			idEx.ctrl <= '0;
		end else begin
			idEx.valid <= decValid & ~flush;
			idEx.ctrl <= flush ? '0 : decCtrl;
			idEx.pcPlus4 <= ifPcPlus4;
			idEx.rsData <= rsData;
			idEx.rtData <= rtData;
			idEx.imm <= immExt;
			idEx.dest <= dest;
		end
	end

endmodule

//--- decode/registerFile.sv
`timescale 1ns/10ps

module registerFile import mipsPkg::*; (
	input logic Clk,
	input logic rstN,
	input regAddr_t rsAddr,
	input regAddr_t rtAddr,
	input memWb_t wr,
	output word_t rsData,
	output word_t rtData
);

	word_t regs [32];

	// Write-through so decode sees the value retiring this cycle
	function automatic word_t readPort(regAddr_t addr);
		if (addr == '0)
			return '0;
		if (wr.valid && wr.dest == addr)
			return wr.data;
		return regs[addr];
	endfunction

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr.valid && wr.dest != '0) begin
			regs[wr.dest] <= wr.data;
		end
	end

	always_comb rsData = readPort(rsAddr);
	always_comb rtData = readPort(rtAddr);

endmodule

//--- decode/controlDecoder.sv
`timescale 1ns/10ps

module controlDecoder import mipsPkg::*; (
	input word_t instr,
	output ctrl_t ctrl,
	output logic valid
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic destZero;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign destZero = (opcode == OpSpecial) ? (instr[15:11] == '0) : (instr[20:16] == '0);

	always_comb begin
		ctrl = '0;
		valid = 1'b1;
		case (opcode)
			OpSpecial: begin
				ctrl.regWrite = 1'b1;
				case (funct)
					FnAdd, FnAddu: ctrl.aluOp = AluAdd;
					FnSub, FnSubu: ctrl.aluOp = AluSub;
					FnAnd: ctrl.aluOp = AluAnd;
					FnOr: ctrl.aluOp = AluOr;
					FnXor: ctrl.aluOp = AluXor;
					FnNor: ctrl.aluOp = AluNor;
					FnSlt: ctrl.aluOp = AluSlt;
					default: begin // All-zero word lands here too
						ctrl = '0;
						valid = 1'b0;
					end
				endcase
			end
			OpAddi, OpAddiu: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = AluAdd;
			end
			OpAndi, OpOri: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.zeroExtend = 1'b1;
				ctrl.aluOp = (opcode == OpAndi) ? AluAnd : AluOr;
			end
			OpLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = AluAdd;
			end
			OpSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = AluAdd;
			end
			OpBeq, OpBne: begin
				ctrl.branchEq = (opcode == OpBeq);
				ctrl.branchNe = (opcode == OpBne);
				ctrl.aluOp = AluSub; // Zero result means equal
			end
			default: valid = 1'b0;
		endcase
		if (destZero)
			ctrl.regWrite = 1'b0; // r0 stays zero and unreported
	end

endmodule

//--- common/mipsPkg.sv
package mipsPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [2:0] aluOp_t;

	localparam aluOp_t AluAnd = 3'd0;
	localparam aluOp_t AluOr = 3'd1;
	localparam aluOp_t AluAdd = 3'd2;
	localparam aluOp_t AluNor = 3'd3;
	localparam aluOp_t AluXor = 3'd4;
	localparam aluOp_t AluSub = 3'd6;
	localparam aluOp_t AluSlt = 3'd7; // Signed compare

	// Opcode field, instr[31:26]
	localparam logic [5:0] OpSpecial = 6'd0;
	localparam logic [5:0] OpBeq = 6'd4;
	localparam logic [5:0] OpBne = 6'd5;
	localparam logic [5:0] OpAddi = 6'd8;
	localparam logic [5:0] OpAddiu = 6'd9;
	localparam logic [5:0] OpAndi = 6'd12;
	localparam logic [5:0] OpOri = 6'd13;
	localparam logic [5:0] OpLw = 6'd35;
	localparam logic [5:0] OpSw = 6'd43;

	// Function field of SPECIAL, instr[5:0]
	localparam logic [5:0] FnAdd = 6'd32;
	localparam logic [5:0] FnAddu = 6'd33;
	localparam logic [5:0] FnSub = 6'd34;
	localparam logic [5:0] FnSubu = 6'd35;
	localparam logic [5:0] FnAnd = 6'd36;
	localparam logic [5:0] FnOr = 6'd37;
	localparam logic [5:0] FnXor = 6'd38;
	localparam logic [5:0] FnNor = 6'd39;
	localparam logic [5:0] FnSlt = 6'd42;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic branchEq;
		logic branchNe;
		logic aluSrcImm; // B operand from immediate
		logic zeroExtend;
		aluOp_t aluOp;
	} ctrl_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		word_t pcPlus4;
		word_t rsData;
		word_t rtData;
		word_t imm;
		regAddr_t dest;
	} idEx_t;

	typedef struct packed {
		logic valid;
		logic regWrite;
		logic memRead;
		logic memWrite;
		word_t aluResult;
		word_t storeData;
		regAddr_t dest;
	} exMem_t;

	typedef struct packed {
		logic valid; // Register write happening
		regAddr_t dest;
		word_t data;
	} memWb_t;

endpackage
